/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address
`define CACHE_ADDR_WIDTH 32

// one word, also one AXI data beat
`define CACHE_DATA_WIDTH 32

// direct mapped, one line per set
`define CACHE_NUM_SETS 16

// words per line, same as beats per fill burst
`define CACHE_LINE_WORDS 4

`endif

/* cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

    localparam int index_w = $clog2(`CACHE_NUM_SETS);
    localparam int word_w  = $clog2(`CACHE_LINE_WORDS);
    localparam int byte_w  = $clog2(`CACHE_DATA_WIDTH / 8);
    localparam int tag_w   = `CACHE_ADDR_WIDTH - index_w - word_w - byte_w;

    typedef struct packed
    {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
        logic [word_w-1:0]  word;
        logic [byte_w-1:0]  byte_off;
    } addr_fields_t;

    // same address word, seen flat or split into fields
    typedef union packed
    {
        logic [`CACHE_ADDR_WIDTH-1:0] flat;
        addr_fields_t                 f;
    } addr_u;

    typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_DATA_WIDTH-1:0] line_t;

    typedef logic [`CACHE_DATA_WIDTH/8-1:0] strb_t;

endpackage

/* mem_req_if.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

interface mem_req_if;

    logic                          req;
    logic                          is_write;
    cache_pkg::addr_u              addr;
    logic [`CACHE_DATA_WIDTH-1:0]  wdata;
    cache_pkg::strb_t              wstrb;

    // line only meaningful while ack is high on a read
    logic                          ack;
    cache_pkg::line_t              line;

    modport cache (output req, is_write, addr, wdata, wstrb, input ack, line);

    modport bridge (input req, is_write, addr, wdata, wstrb, output ack, line);

endinterface

/* cache_core.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_core
(
    input  logic                           clk_in,
    input  logic                           reset_in,
    input  logic                           req,
    input  logic                           is_write,
    input  logic [`CACHE_ADDR_WIDTH-1:0]   addr,
    input  logic [`CACHE_DATA_WIDTH-1:0]   wdata,
    input  cache_pkg::strb_t               byte_mask,
    output logic                           ack,
    output logic [`CACHE_DATA_WIDTH-1:0]   rdata,
    mem_req_if.cache                       mem
);

    typedef enum logic [2:0]
    {
        s_idle,
        s_lookup,
        s_fill_wait,
        s_write_wait,
        s_done
    } state_t;

    state_t                         state;
    cache_pkg::addr_u               req_addr;
    logic                           hit;
    logic [`CACHE_DATA_WIDTH-1:0]   merged_word;
    cache_pkg::line_t               line_buf;

    logic [`CACHE_NUM_SETS-1:0]     valid_arr;
    logic [cache_pkg::tag_w-1:0]    tag_arr [`CACHE_NUM_SETS];
    cache_pkg::line_t               data_arr [`CACHE_NUM_SETS];

    // client holds addr stable for the whole request
    assign req_addr = addr;

    assign hit = valid_arr[req_addr.f.index] &&
                 (tag_arr[req_addr.f.index] == req_addr.f.tag);

    // cached word with the client's bytes laid over it
    always_comb
    begin
        merged_word = data_arr[req_addr.f.index][req_addr.f.word];
        for (int b = 0; b < `CACHE_DATA_WIDTH / 8; b++)
        begin
            if (byte_mask[b])
            begin
                merged_word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state     <= s_idle;
            ack       <= 1'b0;
            rdata     <= '0;
            valid_arr <= '0;
            mem.req   <= 1'b0;
        end
        else
        begin
            case (state)
                s_idle:
                begin
                    if (req)
                    begin
                        state <= s_lookup;
                    end
                end
                s_lookup:
                begin
                    // write through, no allocate
                    if (is_write)
                    begin
                        mem.req <= 1'b1;
                        state   <= s_write_wait;
                    end
                    else if (hit)
                    begin
                        state <= s_done;
                    end
                    else
                    begin
                        mem.req <= 1'b1;
                        state   <= s_fill_wait;
                    end
                end
                s_fill_wait:
                begin
                    if (mem.ack)
                    begin
                        mem.req                     <= 1'b0;
                        valid_arr[req_addr.f.index] <= 1'b1;
                        state                       <= s_done;
                    end
                end
                s_write_wait:
                begin
                    if (mem.ack)
                    begin
                        mem.req <= 1'b0;
                        state   <= s_done;
                    end
                end
                s_done:
                begin
                    if (!ack)
                    begin
                        ack <= 1'b1;
                        if (!is_write)
                        begin
                            rdata <= line_buf[req_addr.f.word];
                        end
                    end
                    else if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= s_idle;
                    end
                end
                default:
                begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // arrays and memory request payload
    always_ff @(posedge clk_in)
    begin
        if (state == s_lookup)
        begin
            line_buf     <= data_arr[req_addr.f.index];
            mem.addr     <= req_addr;
            mem.is_write <= is_write;
            mem.wdata    <= wdata;
            mem.wstrb    <= byte_mask;
            if (is_write && hit)
            begin
                data_arr[req_addr.f.index][req_addr.f.word] <= merged_word;
            end
        end
        else if (state == s_fill_wait && mem.ack)
        begin
            data_arr[req_addr.f.index] <= mem.line;
            tag_arr[req_addr.f.index]  <= req_addr.f.tag;
            line_buf                   <= mem.line;
        end
    end

endmodule

/* axi_mem_bridge.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module axi_mem_bridge
(
    input  logic                           clk_in,
    input  logic                           reset_in,
    mem_req_if.bridge                      mem,

    output logic [`CACHE_ADDR_WIDTH-1:0]   araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [`CACHE_DATA_WIDTH-1:0]   rdata,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready,

    output logic [`CACHE_ADDR_WIDTH-1:0]   awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [`CACHE_DATA_WIDTH-1:0]   wdata,
    output cache_pkg::strb_t               wstrb,
    output logic                           wlast,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready
);

    localparam int off_w = cache_pkg::word_w + cache_pkg::byte_w;

    typedef enum logic [2:0]
    {
        b_idle,
        b_read_addr,
        b_read_data,
        b_write,
        b_write_resp,
        b_ack
    } state_t;

    state_t                         state;
    logic [cache_pkg::word_w-1:0]   beat;
    logic                           aw_done;
    logic                           w_done;

    // every write is a single beat
    assign wlast = 1'b1;

    // channel finished now or earlier
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state   <= b_idle;
            beat    <= '0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            mem.ack <= 1'b0;
        end
        else
        begin
            case (state)
                b_idle:
                begin
                    if (mem.req && mem.is_write)
                    begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= b_write;
                    end
                    else if (mem.req)
                    begin
                        arvalid <= 1'b1;
                        beat    <= '0;
                        state   <= b_read_addr;
                    end
                end
                b_read_addr:
                begin
                    if (arready)
                    begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= b_read_data;
                    end
                end
                b_read_data:
                begin
                    if (rvalid)
                    begin
                        beat <= beat + 1'b1;
                        if (rlast)
                        begin
                            rready  <= 1'b0;
                            mem.ack <= 1'b1;
                            state   <= b_ack;
                        end
                    end
                end
                b_write:
                begin
                    if (awready)
                    begin
                        awvalid <= 1'b0;
                    end
                    if (wready)
                    begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done)
                    begin
                        bready <= 1'b1;
                        state  <= b_write_resp;
                    end
                end
                b_write_resp:
                begin
                    if (bvalid)
                    begin
                        bready <= 1'b0;
                        // slave error, send the same write again
                        if (bresp[1])
                        begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= b_write;
                        end
                        else
                        begin
                            mem.ack <= 1'b1;
                            state   <= b_ack;
                        end
                    end
                end
                b_ack:
                begin
                    if (!mem.req)
                    begin
                        mem.ack <= 1'b0;
                        state   <= b_idle;
                    end
                end
                default:
                begin
                    state <= b_idle;
                end
            endcase
        end
    end

    // addresses, write beat and collected line
    always_ff @(posedge clk_in)
    begin
        if (state == b_idle && mem.req)
        begin
            araddr <= {mem.addr.flat[`CACHE_ADDR_WIDTH-1:off_w], {off_w{1'b0}}};
            awaddr <= mem.addr.flat;
            wdata  <= mem.wdata;
            wstrb  <= mem.wstrb;
        end
        if (state == b_read_data && rvalid)
        begin
            mem.line[beat] <= rdata;
        end
    end

endmodule

/* cache_axi_top.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_axi_top
(
    input  logic                              clk_in,
    input  logic                              reset_in,

    // client
    input  logic                              req,
    input  logic                              is_write,
    input  logic [`CACHE_ADDR_WIDTH-1:0]      addr,
    input  logic [`CACHE_DATA_WIDTH-1:0]      wdata,
    input  logic [`CACHE_DATA_WIDTH/8-1:0]    byte_mask,
    output logic                              ack,
    output logic [`CACHE_DATA_WIDTH-1:0]      rdata,

    // AXI master
    output logic [`CACHE_ADDR_WIDTH-1:0]      axi_araddr,
    output logic                              axi_arvalid,
    input  logic                              axi_arready,
    input  logic [`CACHE_DATA_WIDTH-1:0]      axi_rdata,
    input  logic                              axi_rlast,
    input  logic                              axi_rvalid,
    output logic                              axi_rready,
    output logic [`CACHE_ADDR_WIDTH-1:0]      axi_awaddr,
    output logic                              axi_awvalid,
    input  logic                              axi_awready,
    output logic [`CACHE_DATA_WIDTH-1:0]      axi_wdata,
    output logic [`CACHE_DATA_WIDTH/8-1:0]    axi_wstrb,
    output logic                              axi_wlast,
    output logic                              axi_wvalid,
    input  logic                              axi_wready,
    input  logic [1:0]                        axi_bresp,
    input  logic                              axi_bvalid,
    output logic                              axi_bready
);

    mem_req_if i_mem_req ();

    cache_core i_cache_core
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .req       (req),
        .is_write  (is_write),
        .addr      (addr),
        .wdata     (wdata),
        .byte_mask (byte_mask),
        .ack       (ack),
        .rdata     (rdata),
        .mem       (i_mem_req.cache)
    );

    axi_mem_bridge i_axi_mem_bridge
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .mem      (i_mem_req.bridge),
        .araddr   (axi_araddr),
        .arvalid  (axi_arvalid),
        .arready  (axi_arready),
        .rdata    (axi_rdata),
        .rlast    (axi_rlast),
        .rvalid   (axi_rvalid),
        .rready   (axi_rready),
        .awaddr   (axi_awaddr),
        .awvalid  (axi_awvalid),
        .awready  (axi_awready),
        .wdata    (axi_wdata),
        .wstrb    (axi_wstrb),
        .wlast    (axi_wlast),
        .wvalid   (axi_wvalid),
        .wready   (axi_wready),
        .bresp    (axi_bresp),
        .bvalid   (axi_bvalid),
        .bready   (axi_bready)
    );

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem
(
    input  logic         clk_in,
    input  logic         reset_in,
    // one bit per channel, low stalls that channel for a cycle
    input  logic [4:0]   ready_rand,

    input  logic [31:0]  araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic         rlast,
    output logic         rvalid,
    input  logic         rready,

    input  logic [31:0]  awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [31:0]  wdata,
    input  logic [3:0]   wstrb,
    input  logic         wvalid,
    output logic         wready,
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  logic         bready,

    output int           burst_count,
    output int           write_count
);

    logic [31:0]  mem [4096];
    logic         rd_active;
    logic [9:0]   rd_line;
    logic [1:0]   rd_beat;
    logic         aw_got;
    logic         w_got;
    logic [11:0]  wr_word;
    logic [31:0]  wr_data;
    logic [3:0]   wr_strb;
    logic         wr_commit;

    // every bit of the word address shows up in the pattern
    initial
    begin
        for (int i = 0; i < 4096; i++)
        begin
            mem[i] = {i[11:0], 8'ha5, ~i[11:0]};
        end
    end

    assign arready   = !rd_active && ready_rand[0];
    assign rvalid    = rd_active && ready_rand[1];
    assign rdata     = mem[{rd_line, rd_beat}];
    assign rlast     = (rd_beat == 2'd3);
    assign awready   = !aw_got && ready_rand[2];
    assign wready    = !w_got && ready_rand[3];
    assign bresp     = 2'b00;
    assign wr_commit = aw_got && w_got && !bvalid && ready_rand[4];

    always @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            rd_active   <= 1'b0;
            rd_line     <= '0;
            rd_beat     <= '0;
            aw_got      <= 1'b0;
            w_got       <= 1'b0;
            bvalid      <= 1'b0;
            burst_count <= 0;
            write_count <= 0;
        end
        else
        begin
            if (arvalid && arready)
            begin
                rd_active   <= 1'b1;
                rd_line     <= araddr[13:4];
                rd_beat     <= 2'd0;
                burst_count <= burst_count + 1;
            end
            if (rvalid && rready)
            begin
                rd_beat <= rd_beat + 2'd1;
                if (rlast)
                begin
                    rd_active <= 1'b0;
                end
            end
            if (awvalid && awready)
            begin
                aw_got  <= 1'b1;
                wr_word <= awaddr[13:2];
            end
            if (wvalid && wready)
            begin
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            if (wr_commit)
            begin
                bvalid <= 1'b1;
            end
            if (bvalid && bready)
            begin
                bvalid      <= 1'b0;
                aw_got      <= 1'b0;
                w_got       <= 1'b0;
                write_count <= write_count + 1;
            end
        end
    end

    // memory takes the bytes as the response goes out
    always @(posedge clk_in)
    begin
        if (wr_commit)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (wr_strb[b])
                begin
                    mem[wr_word][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* tb_cache_axi.sv */
`timescale 1ns/1ps

module tb_cache_axi;

    localparam int op_timeout = 200;

    logic         clk_in = 1'b0;
    logic         reset_in;
    logic         req;
    logic         is_write;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [3:0]   byte_mask;
    logic         ack;
    logic [31:0]  rdata;
    logic [4:0]   ready_rand;

    logic [31:0]  axi_araddr;
    logic         axi_arvalid;
    logic         axi_arready;
    logic [31:0]  axi_rdata;
    logic         axi_rlast;
    logic         axi_rvalid;
    logic         axi_rready;
    logic [31:0]  axi_awaddr;
    logic         axi_awvalid;
    logic         axi_awready;
    logic [31:0]  axi_wdata;
    logic [3:0]   axi_wstrb;
    logic         axi_wlast;
    logic         axi_wvalid;
    logic         axi_wready;
    logic [1:0]   axi_bresp;
    logic         axi_bvalid;
    logic         axi_bready;
    int           burst_count;
    int           write_count;

    logic [31:0]  lcg_state = 32'h7be3;
    logic [31:0]  shadow [4096];
    logic         tag_valid [16];
    logic [23:0]  tag_of [16];
    int           bursts_expected = 0;
    int           writes_expected = 0;
    int           checks = 0;
    int           errors = 0;
    logic         hung = 1'b0;
    logic         backpressure = 1'b0;
    logic [31:0]  op_addr = '0;
    logic         op_is_write = 1'b0;
    logic         ack_seen = 1'b0;

    always #50 clk_in = ~clk_in;

    cache_axi_top i_dut
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req         (req),
        .is_write    (is_write),
        .addr        (addr),
        .wdata       (wdata),
        .byte_mask   (byte_mask),
        .ack         (ack),
        .rdata       (rdata),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready)
    );

    tb_axi_mem i_mem
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .ready_rand  (ready_rand),
        .araddr      (axi_araddr),
        .arvalid     (axi_arvalid),
        .arready     (axi_arready),
        .rdata       (axi_rdata),
        .rlast       (axi_rlast),
        .rvalid      (axi_rvalid),
        .rready      (axi_rready),
        .awaddr      (axi_awaddr),
        .awvalid     (axi_awvalid),
        .awready     (axi_awready),
        .wdata       (axi_wdata),
        .wstrb       (axi_wstrb),
        .wvalid      (axi_wvalid),
        .wready      (axi_wready),
        .bresp       (axi_bresp),
        .bvalid      (axi_bvalid),
        .bready      (axi_bready),
        .burst_count (burst_count),
        .write_count (write_count)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] initial_word(input logic [11:0] w);
        return {w, 8'ha5, ~w};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (mask[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return shadow[a[13:2]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic drive_ready_delays();
        logic [31:0] rnd;
        rnd = next_random();
        ready_rand = backpressure ? rnd[20:16] : 5'b11111;
    endtask

    // predicts the outcome, then runs one four-phase request
    task automatic run_op(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] m);
        int cycles;
        if (!hung)
        begin
            @(negedge clk_in);
            if (wr)
            begin
                shadow[a[13:2]] = merge_bytes(shadow[a[13:2]], d, m);
                writes_expected++;
            end
            else if (!tag_valid[a[7:4]] || tag_of[a[7:4]] != a[31:8])
            begin
                bursts_expected++;
                tag_valid[a[7:4]] = 1'b1;
                tag_of[a[7:4]] = a[31:8];
            end
            op_addr = a;
            op_is_write = wr;
            req = 1'b1;
            is_write = wr;
            addr = a;
            wdata = d;
            byte_mask = m;
            cycles = 0;
            while (!ack && cycles < op_timeout)
            begin
                @(negedge clk_in);
                drive_ready_delays();
                cycles++;
            end
            if (!ack)
            begin
                errors++;
                hung = 1'b1;
                $display("timeout: no ack for request at address %h", a);
            end
            else
            begin
                req = 1'b0;
                cycles = 0;
                while (ack && cycles < op_timeout)
                begin
                    @(negedge clk_in);
                    drive_ready_delays();
                    cycles++;
                end
                if (ack)
                begin
                    errors++;
                    hung = 1'b1;
                    $display("timeout: ack stayed high after req fell, address %h", a);
                end
            end
        end
    endtask

    // compares once per ack, while DUT outputs are settled
    always @(negedge clk_in)
    begin
        // AXI request fields while their valid is up
        if (axi_arvalid)
        begin
            check_value("axi_araddr", axi_araddr, {op_addr[31:4], 4'h0});
        end
        if (axi_awvalid)
        begin
            check_value("axi_awaddr", axi_awaddr, op_addr);
        end
        if (axi_wvalid)
        begin
            check_value("axi_wlast", axi_wlast, 32'd1);
        end
        if (ack && !ack_seen)
        begin
            ack_seen = 1'b1;
            if (op_is_write)
            begin
                check_value("axi memory word", i_mem.mem[op_addr[13:2]],
                            expected_word(op_addr));
                check_value("write_count", write_count, writes_expected);
            end
            else
            begin
                check_value("rdata", rdata, expected_word(op_addr));
            end
            check_value("burst_count", burst_count, bursts_expected);
        end
        else if (!ack)
        begin
            ack_seen = 1'b0;
        end
    end

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] line_a;
        logic [31:0] other;
        req = 1'b0;
        is_write = 1'b0;
        addr = '0;
        wdata = '0;
        byte_mask = '0;
        ready_rand = 5'b11111;
        reset_in = 1'b1;
        for (int i = 0; i < 4096; i++)
        begin
            shadow[i] = initial_word(i[11:0]);
        end
        for (int s = 0; s < 16; s++)
        begin
            tag_valid[s] = 1'b0;
            tag_of[s] = '0;
        end
        repeat (2) @(negedge clk_in);
        reset_in = 1'b0;

        rnd = next_random();
        line_a = {18'h0, rnd[13:4], 4'h0};
        // miss, then another word of the same line
        run_op(1'b0, line_a + 32'h4, '0, '0);
        run_op(1'b0, line_a + 32'hc, '0, '0);
        // write hit with a partial mask
        rnd = next_random();
        run_op(1'b1, line_a + 32'h4, next_random(), {rnd[3:2], 2'b01});
        run_op(1'b0, line_a + 32'h4, '0, '0);
        // write miss in the next set, no allocate
        other = line_a ^ 32'h10;
        rnd = next_random();
        run_op(1'b1, other, next_random(), {rnd[3:2], 2'b10});
        run_op(1'b0, other, '0, '0);
        // same index, different tag
        other = line_a ^ 32'h1000;
        repeat (2)
        begin
            run_op(1'b0, line_a + 32'h8, '0, '0);
            run_op(1'b0, other + 32'h8, '0, '0);
        end

        backpressure = 1'b1;
        for (int n = 0; n < 200; n++)
        begin
            rnd = next_random();
            run_op(rnd[31], rnd & 32'h3fc, next_random(), rnd[23:20]);
        end
        repeat (2) @(negedge clk_in);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
cache_pkg.sv
mem_req_if.sv
cache_core.sv
axi_mem_bridge.sv
cache_axi_top.sv
tb_axi_mem.sv
tb_cache_axi.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_cache_axi -o sim_tb \
    && output="$(./obj_dir/sim_tb)" \
    && echo "$output" \
    && grep -q "All checks passed" <<< "$output" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
